//--- filelist.f
hdl/exec_pkg.sv
hdl/register_file.sv
hdl/issue_stage.sv
hdl/hazard_detector.sv
hdl/bypass_controller.sv
hdl/alu_stage.sv
hdl/commit_stage.sv
hdl/exec_pipeline_top.sv
tests/exec_pipeline_tb.sv

//--- tests/exec_pipeline_tb.sv
// Table-driven testbench for exec_pipeline_top; run it as the simulation top with filelist.f

`timescale 1ns/1ps

module exec_pipeline_tb import exec_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int TABLE_LEN  = 49;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       instr_valid_i;
    logic [31:0] instr_word;
    logic       commit_valid_o;
    reg_addr_t  commit_rd_o;
    data_word_t commit_data_o;

    // Stimulus table with the expected commit filled in by the register model
    logic       tbl_valid  [TABLE_LEN];
    logic [31:0] tbl_word  [TABLE_LEN];
    int         tbl_test   [TABLE_LEN];
    logic       tbl_writes [TABLE_LEN];
    reg_addr_t  tbl_rd     [TABLE_LEN];
    data_word_t tbl_data   [TABLE_LEN];
    int         n_entries = 0;

    // Table indices of issued instructions that have not committed yet
    int         exp_q [$];

    string      test_name   [1:6];
    int         pending     [1:6] = '{default: 0};
    int         test_errors [1:6] = '{default: 0};
    int         cur_test = 1;
    int         checks = 0;
    int         errors = 0;
    integer     seed = 32'h0af2_d7a1;

    exec_pipeline_top uut (
        .clk_i (clk_i), .reset_i (reset_i),
        .instr_valid_i (instr_valid_i), .instr_i (instr_word),
        .commit_valid_o (commit_valid_o), .commit_rd_o (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Instruction encoding and the register model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] encode_reg(input logic [3:0] op, input reg_addr_t rd,
                                               input reg_addr_t rs0, input reg_addr_t rs1);
        return {op, rd, rs0, rs1, 19'b0};
    endfunction

    // The immediate occupies bits 21:1, so its top three bits alias rs1
    function automatic logic [31:0] encode_imm(input logic [3:0] op, input reg_addr_t rd,
                                               input reg_addr_t rs0, input logic [20:0] imm);
        return {op, rd, rs0, imm, 1'b0};
    endfunction

    task automatic add_entry(input logic valid, input int test, input logic [31:0] word);
        tbl_valid[n_entries] = valid;
        tbl_test[n_entries]  = test;
        tbl_word[n_entries]  = word;
        if (valid) begin
            pending[test]++;
        end
        n_entries++;
    endtask

    // Runs the table in program order, as if every instruction finished before the next
    task automatic compute_expected();
        data_word_t  model [8];
        logic [3:0]  op;
        logic [31:0] w;
        data_word_t  src0, src1, imm_ext, result;
        for (int r = 0; r < 8; r++) begin
            model[r] = '0;
        end
        for (int i = 0; i < n_entries; i++) begin
            w       = tbl_word[i];
            op      = w[31:28];
            imm_ext = {{11{w[21]}}, w[21:1]};
            src0    = model[w[24:22]];
            src1    = model[w[21:19]];
            case (op)
                OP_ADD:  result = src0 + src1;
                OP_SUB:  result = src0 - src1;
                OP_AND:  result = src0 & src1;
                OP_OR:   result = src0 | src1;
                OP_XOR:  result = src0 ^ src1;
                OP_SLL:  result = src0 << src1[4:0];
                OP_ADDI: result = src0 + imm_ext;
                OP_MOVI: result = imm_ext;
                default: result = '0;
            endcase
            tbl_writes[i] = tbl_valid[i] && (op >= 4'h1) && (op <= 4'h8);
            tbl_rd[i]     = w[27:25];
            tbl_data[i]   = result;
            if (tbl_writes[i]) begin
                model[w[27:25]] = result;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic build_table();
        logic [31:0] r1, r2;
        logic [3:0]  op;
        // Registers that were never written read zero
        add_entry(1, 1, encode_reg(OP_ADD, 3'd1, 3'd2, 3'd3));
        add_entry(1, 1, encode_reg(OP_ADD, 3'd4, 3'd5, 3'd6));
        // At distance 1 both operands come from the execute stage
        add_entry(1, 2, encode_imm(OP_MOVI, 3'd1, 3'd0, 21'd11));
        add_entry(1, 2, encode_reg(OP_ADD, 3'd2, 3'd1, 3'd1));
        add_entry(1, 2, encode_reg(OP_ADD, 3'd3, 3'd2, 3'd1));
        // Distance 2 reads from commit, then r7 is live in both stages at once
        add_entry(1, 3, encode_imm(OP_MOVI, 3'd4, 3'd0, 21'd100));
        add_entry(1, 3, encode_imm(OP_MOVI, 3'd5, 3'd0, 21'd3));
        add_entry(1, 3, encode_reg(OP_SUB, 3'd6, 3'd4, 3'd5));
        add_entry(1, 3, encode_imm(OP_MOVI, 3'd7, 3'd0, 21'd1));
        add_entry(1, 3, encode_imm(OP_MOVI, 3'd7, 3'd0, 21'd2));
        add_entry(1, 3, encode_reg(OP_ADD, 3'd0, 3'd7, 3'd7));
        // Distance 3 goes through the register file write-through
        add_entry(1, 4, encode_imm(OP_MOVI, 3'd1, 3'd0, 21'h55));
        add_entry(1, 4, encode_imm(OP_MOVI, 3'd2, 3'd0, 21'h66));
        add_entry(1, 4, encode_imm(OP_MOVI, 3'd3, 3'd0, 21'h77));
        add_entry(1, 4, encode_reg(OP_XOR, 3'd4, 3'd1, 3'd2));
        add_entry(1, 4, encode_imm(OP_MOVI, 3'd5, 3'd0, 21'd9));
        // Words in the gap must neither commit nor forward
        add_entry(0, 4, encode_imm(OP_MOVI, 3'd5, 3'd0, 21'h1234));
        add_entry(0, 4, encode_reg(OP_ADD, 3'd5, 3'd1, 3'd2));
        add_entry(1, 4, encode_reg(OP_OR, 3'd6, 3'd5, 3'd5));
        add_entry(1, 4, encode_reg(OP_SLL, 3'd7, 3'd6, 3'd3));
        // Immediate top bits name the register written just before
        r1 = $random(seed);
        add_entry(1, 5, encode_imm(OP_MOVI, 3'd3, 3'd0, {3'd0, r1[17:0]}));
        r1 = $random(seed);
        add_entry(1, 5, encode_imm(OP_ADDI, 3'd1, 3'd3, {3'd3, r1[17:0]}));
        r1 = $random(seed);
        add_entry(1, 5, encode_imm(OP_ADDI, 3'd2, 3'd3, {3'd1, r1[17:0]}));
        r1 = $random(seed);
        add_entry(1, 5, encode_imm(OP_MOVI, 3'd4, 3'd1, {3'd2, r1[17:0]}));
        r1 = $random(seed);
        add_entry(1, 5, encode_imm(OP_MOVI, 3'd5, 3'd4, {3'd4, r1[17:0]}));
        // The random run loads every register with a random value first
        for (int r = 0; r < 8; r++) begin
            r1 = $random(seed);
            add_entry(1, 6, encode_imm(OP_MOVI, r[2:0], 3'd0, r1[20:0]));
        end
        for (int i = 0; i < 16; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            op = {1'b0, r1[2:0]} + 4'd1;
            if (op == OP_ADDI || op == OP_MOVI) begin
                add_entry(1, 6, encode_imm(op, r1[10:8], r1[13:11], r2[20:0]));
            end else begin
                add_entry(1, 6, encode_reg(op, r1[10:8], r1[13:11], r1[16:14]));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------

    task automatic compare(input data_word_t actual, input data_word_t expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors[cur_test]++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // Runs on every falling edge where the commit outputs are stable
    task automatic check_commit();
        int idx;
        if (commit_valid_o !== 1'b0 && commit_valid_o !== 1'b1) begin
            errors++;
            test_errors[cur_test]++;
            $display("Error at %0t ns: commit_valid_o is unknown", $time);
        end else if (commit_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                test_errors[cur_test]++;
                $display("Error at %0t ns: commit of r%0d with no instruction outstanding",
                         $time, commit_rd_o);
            end else begin
                idx      = exp_q.pop_front();
                cur_test = tbl_test[idx];
                if (tbl_writes[idx]) begin
                    compare(commit_rd_o, tbl_rd[idx], $sformatf("entry %0d rd", idx));
                    compare(commit_data_o, tbl_data[idx], $sformatf("entry %0d data", idx));
                end
                pending[cur_test]--;
                if (pending[cur_test] == 0) begin
                    $display("test %0d %s: %s, %0d errors", cur_test, test_name[cur_test],
                             (test_errors[cur_test] == 0) ? "ok" : "failed",
                             test_errors[cur_test]);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        $timeformat(-9, 0, "", 0);
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_word    = '0;
        test_name[1]  = "reset state";
        test_name[2]  = "execute bypass";
        test_name[3]  = "commit bypass and priority";
        test_name[4]  = "write-through and gaps";
        test_name[5]  = "immediate aliasing";
        test_name[6]  = "random run";
        build_table();
        compute_expected();

        repeat (3) begin
            @(negedge clk_i);
            check_commit();
        end
        reset_i = 1'b0;

        // Check first so the commit of an older entry is seen before a new push
        for (int i = 0; i < n_entries; i++) begin
            @(negedge clk_i);
            check_commit();
            instr_valid_i = tbl_valid[i];
            instr_word    = tbl_word[i];
            if (tbl_valid[i]) begin
                exp_q.push_back(i);
            end
        end

        while (exp_q.size() > 0) begin
            @(negedge clk_i);
            check_commit();
            instr_valid_i = 1'b0;
        end

        // Nothing more may commit once the table is drained
        repeat (3) begin
            @(negedge clk_i);
            check_commit();
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // The watchdog allows the whole table plus room for reset and draining
    initial begin
        #((TABLE_LEN + 20) * CLK_PERIOD);
        $display("Timeout at %0t ns: %0d commits still outstanding", $time, exp_q.size());
        $display("TEST FAIL");
        $finish;
    end

endmodule : exec_pipeline_tb

//--- hdl/exec_pipeline_top.sv
// Top level of the operand path; instructions in, committed results out three edges later

`timescale 1ns/1ps

module exec_pipeline_top import exec_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Instruction feed, one per cycle, no back-pressure
    input  logic       instr_valid_i,
    input  instr_t     instr_i,

    // Committed result, one per issued instruction, in order
    output logic       commit_valid_o,
    output reg_addr_t  commit_rd_o,
    output data_word_t commit_data_o
);

    // ------------------------------------------------------------------------
    // Stage wires
    // ------------------------------------------------------------------------

    reg_addr_t        raddr0, raddr1;
    data_word_t       rdata0, rdata1;

    logic             is_valid, is_we;
    opcode_t          is_opcode;
    reg_addr_t        is_rd, is_rs0, is_rs1;
    logic       [1:0] is_immediate;
    data_word_t [1:0] is_operand;

    logic       [1:0] execute_valid, commit_valid;
    data_word_t [1:0] alu_operand;

    logic             ex_valid, ex_we, cm_valid, cm_we;
    reg_addr_t        ex_rd, cm_rd;
    data_word_t       ex_data, cm_data;

    // ------------------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------------------

    // The commit stage writes back, three ahead of the instruction reading
    register_file u_register_file (
        .clk_i (clk_i), .reset_i (reset_i),
        .raddr0_i (raddr0), .raddr1_i (raddr1),
        .we_i (cm_we), .waddr_i (cm_rd), .wdata_i (cm_data),
        .rdata0_o (rdata0), .rdata1_o (rdata1)
    );

    issue_stage u_issue_stage (
        .clk_i (clk_i), .reset_i (reset_i),
        .instr_valid_i (instr_valid_i), .instr_i (instr_i),
        .rdata0_i (rdata0), .rdata1_i (rdata1),
        .raddr0_o (raddr0), .raddr1_o (raddr1),
        .valid_o (is_valid), .we_o (is_we), .opcode_o (is_opcode),
        .rd_o (is_rd), .rs0_o (is_rs0), .rs1_o (is_rs1),
        .immediate_o (is_immediate), .operand_o (is_operand)
    );

    hazard_detector u_hazard_detector (
        .issue_rs0_i (is_rs0), .issue_rs1_i (is_rs1),
        .ex_valid_i (ex_valid), .ex_we_i (ex_we), .ex_rd_i (ex_rd),
        .cm_valid_i (cm_valid), .cm_we_i (cm_we), .cm_rd_i (cm_rd),
        .execute_valid_o (execute_valid), .commit_valid_o (commit_valid)
    );

    // Each bypass source carries one copy of the stage result per operand
    bypass_controller u_bypass_controller (
        .issue_operand_i (is_operand), .issue_immediate_i (is_immediate),
        .execute_data_i ({ex_data, ex_data}), .execute_valid_i (execute_valid),
        .commit_data_i ({cm_data, cm_data}), .commit_valid_i (commit_valid),
        .operand_o (alu_operand)
    );

    alu_stage u_alu_stage (
        .clk_i (clk_i), .reset_i (reset_i),
        .valid_i (is_valid), .we_i (is_we), .opcode_i (is_opcode),
        .rd_i (is_rd), .operand_i (alu_operand),
        .valid_o (ex_valid), .we_o (ex_we), .rd_o (ex_rd), .result_o (ex_data)
    );

    commit_stage u_commit_stage (
        .clk_i (clk_i), .reset_i (reset_i),
        .valid_i (ex_valid), .we_i (ex_we), .rd_i (ex_rd), .result_i (ex_data),
        .valid_o (cm_valid), .we_o (cm_we), .rd_o (cm_rd), .data_o (cm_data)
    );

    assign commit_valid_o = cm_valid;
    assign commit_rd_o    = cm_rd;
    assign commit_data_o  = cm_data;

endmodule : exec_pipeline_top

//--- hdl/commit_stage.sv
// Commit stage; holds the result that is written back and shown on the commit outputs

`timescale 1ns/1ps

module commit_stage import exec_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Result leaving the execute stage
    input  logic       valid_i,
    input  logic       we_i,
    input  reg_addr_t  rd_i,
    input  data_word_t result_i,

    // Committed instruction, feeds the write port and the commit bypass
    output logic       valid_o,
    output logic       we_o,
    output reg_addr_t  rd_o,
    output data_word_t data_o
);

    // A NOP still commits, but it leaves we_o low so nothing is written
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= valid_i;
            we_o    <= valid_i & we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_o   <= rd_i;
        data_o <= result_i;
    end

endmodule : commit_stage

//--- hdl/alu_stage.sv
// Execute stage; computes the ALU result on the bypassed operands and registers it

`timescale 1ns/1ps

module alu_stage import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             reset_i,

    // Instruction in its execute cycle
    input  logic             valid_i,
    input  logic             we_i,
    input  opcode_t          opcode_i,
    input  reg_addr_t        rd_i,
    input  data_word_t [1:0] operand_i,

    // Registered result, also the execute bypass source
    output logic             valid_o,
    output logic             we_o,
    output reg_addr_t        rd_o,
    output data_word_t       result_o
);

    data_word_t result;

    // ------------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------------

    // ADDI and MOVI share the adder, MOVI arrives with operand 0 at zero
    always_comb begin
        case (opcode_i)
            OP_ADD, OP_ADDI, OP_MOVI: result = operand_i[0] + operand_i[1];
            OP_SUB:  result = operand_i[0] - operand_i[1];
            OP_AND:  result = operand_i[0] & operand_i[1];
            OP_OR:   result = operand_i[0] | operand_i[1];
            OP_XOR:  result = operand_i[0] ^ operand_i[1];

            // Only the low 5 bits of the shift amount count
            OP_SLL:  result = operand_i[0] << operand_i[1][4:0];

            default: result = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Execute register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= valid_i;
            we_o    <= valid_i & we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_o     <= rd_i;
        result_o <= result;
    end

endmodule : alu_stage

//--- hdl/bypass_controller.sv
// Bypass controller; picks each ALU operand from execute, commit or the issued value

`timescale 1ns/1ps

module bypass_controller import exec_pkg::*; (
    // Operands read at issue, and which of them are immediates
    input  data_word_t [1:0] issue_operand_i,
    input  logic       [1:0] issue_immediate_i,

    // Result of the execute stage with its match flags
    input  data_word_t [1:0] execute_data_i,
    input  logic       [1:0] execute_valid_i,

    // Result of the commit stage with its match flags
    input  data_word_t [1:0] commit_data_i,
    input  logic       [1:0] commit_valid_i,

    // Operands handed to the ALU
    output data_word_t [1:0] operand_o
);

    logic [1:0] use_execute, use_commit;

    // An immediate never depends on a register, so it cannot be replaced
    assign use_execute = execute_valid_i & ~issue_immediate_i;
    assign use_commit  = commit_valid_i & ~issue_immediate_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // The execute stage holds the youngest value and wins over commit
            if (use_execute[i]) begin
                operand_o[i] = execute_data_i[i];
            end else if (use_commit[i]) begin
                operand_o[i] = commit_data_i[i];
            end else begin
                operand_o[i] = issue_operand_i[i];
            end
        end
    end

endmodule : bypass_controller

//--- hdl/hazard_detector.sv
// Hazard detector; flags which issued sources match the execute or commit destination

`timescale 1ns/1ps

module hazard_detector import exec_pkg::*; (
    // Source registers of the instruction entering execute
    input  reg_addr_t  issue_rs0_i,
    input  reg_addr_t  issue_rs1_i,

    // Destination of the instruction one ahead
    input  logic       ex_valid_i,
    input  logic       ex_we_i,
    input  reg_addr_t  ex_rd_i,

    // Destination of the instruction two ahead
    input  logic       cm_valid_i,
    input  logic       cm_we_i,
    input  reg_addr_t  cm_rd_i,

    // One flag per operand for each bypass source
    output logic [1:0] execute_valid_o,
    output logic [1:0] commit_valid_o
);

    reg_addr_t [1:0] issue_rs;
    logic            ex_writes, cm_writes;

    assign issue_rs  = {issue_rs1_i, issue_rs0_i};

    // A stage only forwards when it holds a live instruction that writes
    assign ex_writes = ex_valid_i & ex_we_i;
    assign cm_writes = cm_valid_i & cm_we_i;

    // Immediates are not masked here, the bypass controller drops those flags
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            execute_valid_o[i] = ex_writes && (ex_rd_i == issue_rs[i]);
            commit_valid_o[i]  = cm_writes && (cm_rd_i == issue_rs[i]);
        end
    end

endmodule : hazard_detector

//--- hdl/issue_stage.sv
// Issue stage; decodes the instruction word, reads the sources and registers them for execute

`timescale 1ns/1ps

module issue_stage import exec_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Instruction feed, sampled on every rising edge
    input  logic                   instr_valid_i,
    input  instr_t                 instr_i,

    // Register file read port
    input  data_word_t             rdata0_i,
    input  data_word_t             rdata1_i,
    output reg_addr_t              raddr0_o,
    output reg_addr_t              raddr1_o,

    // Registered instruction for the execute cycle
    output logic                   valid_o,
    output logic                   we_o,
    output opcode_t                opcode_o,
    output reg_addr_t              rd_o,
    output reg_addr_t              rs0_o,
    output reg_addr_t              rs1_o,
    output logic       [1:0]       immediate_o,
    output data_word_t [1:0]       operand_o
);

    opcode_t          opcode;
    logic             writes_reg;
    logic       [1:0] immediate;
    data_word_t [1:0] operand;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    // The opcode, rd and rs0 sit in the same bits in both formats
    assign opcode   = instr_i.reg_fmt.opcode;
    assign raddr0_o = instr_i.reg_fmt.rs0;

    // The rs1 read is harmless for immediate formats, the value is dropped below
    assign raddr1_o = instr_i.reg_fmt.rs1;

    always_comb begin
        writes_reg = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL,
                                    OP_ADDI, OP_MOVI};

        // Operand 1 takes the sign-extended immediate in the immediate format
        immediate[1] = opcode inside {OP_ADDI, OP_MOVI};

        // A move adds the immediate to a zero operand 0
        immediate[0] = (opcode == OP_MOVI);

        operand[0] = immediate[0] ? '0 : rdata0_i;
        operand[1] = immediate[1] ?
                     {{(DATA_WIDTH - IMM_WIDTH){instr_i.imm_fmt.immediate[IMM_WIDTH - 1]}},
                      instr_i.imm_fmt.immediate} : rdata1_i;
    end

    // ------------------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= instr_valid_i;
            we_o    <= instr_valid_i & writes_reg;
        end
    end

    // Payload follows the instruction, its meaning rides on valid_o
    always_ff @(posedge clk_i) begin
        opcode_o    <= opcode;
        rd_o        <= instr_i.reg_fmt.rd;
        rs0_o       <= instr_i.reg_fmt.rs0;
        rs1_o       <= instr_i.reg_fmt.rs1;
        immediate_o <= immediate;
        operand_o   <= operand;
    end

endmodule : issue_stage

//--- hdl/register_file.sv
// Eight-entry register file with two combinational read ports and write-through

`timescale 1ns/1ps

module register_file import exec_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Read ports, driven by the issue stage
    input  reg_addr_t  raddr0_i,
    input  reg_addr_t  raddr1_i,

    // Write port, driven by the commit stage
    input  logic       we_i,
    input  reg_addr_t  waddr_i,
    input  data_word_t wdata_i,

    output data_word_t rdata0_o,
    output data_word_t rdata1_o
);

    data_word_t regs [NUM_REGS];

    // Every register reads zero after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // A read of the register being written returns the new value, so the
    // instruction three behind the writer sees its result without a bypass
    always_comb begin
        rdata0_o = (we_i && (waddr_i == raddr0_i)) ? wdata_i : regs[raddr0_i];
        rdata1_o = (we_i && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
    end

endmodule : register_file

//--- hdl/exec_pkg.sv
// Shared widths, opcodes and instruction formats; import it into every module of the pipeline

package exec_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    // Width of a register and of every data word on the operand path
    localparam int DATA_WIDTH = 32;

    // Width of a register number, eight registers in the file
    localparam int REG_ADDR_WIDTH = 3;
    localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

    // Width of the immediate field in the immediate format
    localparam int IMM_WIDTH = 21;

    typedef logic [DATA_WIDTH - 1:0] data_word_t;
    typedef logic [REG_ADDR_WIDTH - 1:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------

    // Codes above OP_MOVI are not defined and behave as OP_NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SLL  = 4'h6,
        OP_ADDI = 4'h7,
        OP_MOVI = 4'h8
    } opcode_t;

    // ------------------------------------------------------------------------
    // Instruction word
    // ------------------------------------------------------------------------

    // Register format, both sources come from the register file
    typedef struct packed {
        opcode_t         opcode;
        reg_addr_t       rd;
        reg_addr_t       rs0;
        reg_addr_t       rs1;
        logic [18:0]     unused;
    } instr_reg_t;

    // Immediate format, the rs1 bits are read as the top of the immediate
    typedef struct packed {
        opcode_t                opcode;
        reg_addr_t              rd;
        reg_addr_t              rs0;
        logic [IMM_WIDTH - 1:0] immediate;
        logic                   unused;
    } instr_imm_t;

    // The same 32 bits, decoded in one view or the other by the opcode
    typedef union packed {
        instr_reg_t reg_fmt;
        instr_imm_t imm_fmt;
    } instr_t;

endpackage : exec_pkg
